//--- hw/cavlc_macros.svh
`ifndef CAVLC_MACROS_SVH
`define CAVLC_MACROS_SVH

// Coefficients in one 4x4 residual block.
`define CAVLC_BLOCK_SIZE 16

// Width of the scan index over one block.
`define CAVLC_IDX_W 4

// CAVLC codes at most three trailing ones.
`define CAVLC_MAX_T1 3

// Width of the block position coordinates.
`define CAVLC_POS_W 10

`endif

//--- hw/cavlc_pkg.sv
`default_nettype none

`include "cavlc_macros.svh"

package cavlc_pkg;

    // Quantized input coefficient.
    typedef logic signed [7:0] coeff_t;

    // Entry of the remaining level list.
    typedef logic signed [7:0] level_t;

    // Run lengths and counts, 0 to 16.
    typedef logic [4:0] run_t;

    // Bit k set when the k-th trailing one is negative.
    typedef logic [`CAVLC_MAX_T1-1:0] t1_flags_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SCAN,
        HOLD
    } scan_state_t;

endpackage

`default_nettype wire

//--- hw/coeff_scan_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

interface coeff_scan_if;

    cavlc_pkg::coeff_t          coeff;
    logic                       scan_en;
    logic                       clear;
    logic [`CAVLC_IDX_W-1:0]    scan_idx;

    modport ctrl (
        output scan_en,
        output clear,
        output scan_idx
    );

    // Block buffer looks up the coefficient at the scan position.
    modport src (
        input  scan_idx,
        output coeff
    );

    modport unit (
        input  coeff,
        input  scan_en,
        input  clear,
        input  scan_idx
    );

endinterface

`default_nettype wire

//--- hw/cavlc_block_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

module cavlc_block_buffer (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           load_i,
    input  cavlc_pkg::coeff_t   block_i [`CAVLC_BLOCK_SIZE],
    coeff_scan_if.src           scan
);

    cavlc_pkg::coeff_t          mem [`CAVLC_BLOCK_SIZE];
    logic [`CAVLC_IDX_W-1:0]    raster_idx;

    // Raster index of reverse zig-zag position k.
    function automatic logic [`CAVLC_IDX_W-1:0] raster_of(input logic [`CAVLC_IDX_W-1:0] k);
        case (k)
            4'd0:    raster_of = 4'd15;
            4'd1:    raster_of = 4'd14;
            4'd2:    raster_of = 4'd11;
            4'd3:    raster_of = 4'd7;
            4'd4:    raster_of = 4'd10;
            4'd5:    raster_of = 4'd13;
            4'd6:    raster_of = 4'd12;
            4'd7:    raster_of = 4'd9;
            4'd8:    raster_of = 4'd6;
            4'd9:    raster_of = 4'd3;
            4'd10:   raster_of = 4'd2;
            4'd11:   raster_of = 4'd5;
            4'd12:   raster_of = 4'd8;
            4'd13:   raster_of = 4'd4;
            4'd14:   raster_of = 4'd1;
            default: raster_of = 4'd0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CAVLC_BLOCK_SIZE; i++) begin
                mem[i] <= '0;
            end
        end else if (load_i) begin
            mem <= block_i;
        end
    end

    assign raster_idx = raster_of(scan.scan_idx);
    assign scan.coeff = mem[raster_idx];

endmodule

`default_nettype wire

//--- hw/cavlc_scan_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

module cavlc_scan_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       stream_reset_i,
    input  wire logic                       valid_i,
    input  wire logic                       enc_ready_i,
    input  wire logic [`CAVLC_POS_W-1:0]    pos_x_i,
    input  wire logic [`CAVLC_POS_W-1:0]    pos_y_i,
    output logic                            load_o,
    output logic                            ready_o,
    output logic                            valid_o,
    output logic [`CAVLC_POS_W-1:0]         pos_x_o,
    output logic [`CAVLC_POS_W-1:0]         pos_y_o,
    coeff_scan_if.ctrl                      scan
);

    localparam int LAST_IDX = `CAVLC_BLOCK_SIZE - 1;

    cavlc_pkg::scan_state_t     state;
    cavlc_pkg::scan_state_t     state_next;
    logic [`CAVLC_IDX_W-1:0]    idx;
    logic                       last_idx;

    assign last_idx = (int'(idx) == LAST_IDX);

    // Stream reset has priority over every transition.
    always_comb begin
        state_next = state;
        if (stream_reset_i) begin
            state_next = cavlc_pkg::IDLE;
        end else begin
            case (state)
                cavlc_pkg::IDLE: if (valid_i) state_next = cavlc_pkg::LOAD;
                cavlc_pkg::LOAD: state_next = cavlc_pkg::SCAN;
                cavlc_pkg::SCAN: if (last_idx) state_next = cavlc_pkg::HOLD;
                cavlc_pkg::HOLD: if (enc_ready_i) state_next = cavlc_pkg::IDLE;
                default:         state_next = cavlc_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cavlc_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Index wraps back to zero after the last scan step.
    always_ff @(posedge clk) begin
        if (rst || stream_reset_i || load_o) begin
            idx <= '0;
        end else if (scan.scan_en) begin
            idx <= idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || stream_reset_i) begin
            pos_x_o <= '0;
            pos_y_o <= '0;
        end else if (load_o) begin
            pos_x_o <= pos_x_i;
            pos_y_o <= pos_y_i;
        end
    end

    assign load_o        = (state_next == cavlc_pkg::LOAD);
    assign ready_o       = (state == cavlc_pkg::IDLE);
    assign valid_o       = (state == cavlc_pkg::HOLD);
    assign scan.scan_en  = (state == cavlc_pkg::SCAN);
    assign scan.clear    = (state_next == cavlc_pkg::IDLE);
    assign scan.scan_idx = idx;

endmodule

`default_nettype wire

//--- hw/coeff_count_unit.sv
`timescale 1ns/1ps
`default_nettype none

module coeff_count_unit (
    input  wire logic       clk,
    input  wire logic       rst,
    coeff_scan_if.unit      scan,
    output cavlc_pkg::run_t total_coeff_o,
    output cavlc_pkg::run_t total_zeros_o
);

    logic nonzero;
    logic seen_nonzero;

    assign nonzero      = (scan.coeff != '0);
    assign seen_nonzero = (total_coeff_o != '0);

    always_ff @(posedge clk) begin
        if (rst || scan.clear) begin
            total_coeff_o <= '0;
        end else if (scan.scan_en && nonzero) begin
            total_coeff_o <= total_coeff_o + 1'b1;
        end
    end

    // Reverse scan, so zeros after the first nonzero lie below the
    // highest-frequency nonzero coefficient.
    always_ff @(posedge clk) begin
        if (rst || scan.clear) begin
            total_zeros_o <= '0;
        end else if (scan.scan_en && !nonzero && seen_nonzero) begin
            total_zeros_o <= total_zeros_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/trailing_ones_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

module trailing_ones_unit (
    input  wire logic               clk,
    input  wire logic               rst,
    coeff_scan_if.unit              scan,
    output logic [1:0]              t1_count_o,
    output cavlc_pkg::t1_flags_t    t1_flags_o,
    output logic                    t1_done_o
);

    localparam logic [1:0] LAST_T1 = 2'(`CAVLC_MAX_T1 - 1);

    logic nonzero;
    logic is_one;
    logic done_r;

    assign nonzero = (scan.coeff != '0);
    assign is_one  = (scan.coeff == 8'sd1) || (scan.coeff == -8'sd1);

    always_ff @(posedge clk) begin
        if (rst || scan.clear) begin
            t1_count_o <= '0;
            t1_flags_o <= '0;
            done_r     <= 1'b0;
        end else if (scan.scan_en && !done_r && nonzero) begin
            if (is_one) begin
                t1_flags_o[t1_count_o] <= scan.coeff[7];
                t1_count_o             <= t1_count_o + 1'b1;
                if (t1_count_o == LAST_T1) begin
                    done_r <= 1'b1;
                end
            end else begin
                done_r <= 1'b1;
            end
        end
    end

    // The coefficient that ends the run is already a level in its own cycle.
    assign t1_done_o = done_r || (nonzero && !is_one);

endmodule

`default_nettype wire

//--- hw/level_list_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

module level_list_unit (
    input  wire logic           clk,
    input  wire logic           rst,
    coeff_scan_if.unit          scan,
    input  wire logic           t1_done_i,
    output cavlc_pkg::level_t   level_list_o [`CAVLC_BLOCK_SIZE],
    output cavlc_pkg::run_t     level_count_o
);

    logic                       append;
    logic [`CAVLC_IDX_W-1:0]    wr_idx;

    assign append = scan.scan_en && t1_done_i && (scan.coeff != '0);
    assign wr_idx = level_count_o[`CAVLC_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (rst || scan.clear) begin
            level_count_o <= '0;
        end else if (append) begin
            level_count_o <= level_count_o + 1'b1;
        end
    end

    // Entries past the count read back as zero.
    always_ff @(posedge clk) begin
        if (rst || scan.clear) begin
            for (int i = 0; i < `CAVLC_BLOCK_SIZE; i++) begin
                level_list_o[i] <= '0;
            end
        end else if (append) begin
            level_list_o[wr_idx] <= cavlc_pkg::level_t'(scan.coeff);
        end
    end

endmodule

`default_nettype wire

//--- hw/run_before_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

module run_before_unit (
    input  wire logic           clk,
    input  wire logic           rst,
    coeff_scan_if.unit          scan,
    output cavlc_pkg::run_t     run_list_o [`CAVLC_BLOCK_SIZE],
    output cavlc_pkg::run_t     run_count_o
);

    logic                       nonzero;
    logic                       open_run;
    logic [`CAVLC_IDX_W-1:0]    new_idx;
    logic [`CAVLC_IDX_W-1:0]    cur_idx;

    assign nonzero  = (scan.coeff != '0);
    assign open_run = (run_count_o != '0);
    assign new_idx  = run_count_o[`CAVLC_IDX_W-1:0];
    assign cur_idx  = new_idx - 1'b1;

    always_ff @(posedge clk) begin
        if (rst || scan.clear) begin
            run_count_o <= '0;
        end else if (scan.scan_en && nonzero) begin
            run_count_o <= run_count_o + 1'b1;
        end
    end

    // A nonzero opens a new entry, zeros extend the last one.
    always_ff @(posedge clk) begin
        if (rst || scan.clear) begin
            for (int i = 0; i < `CAVLC_BLOCK_SIZE; i++) begin
                run_list_o[i] <= '0;
            end
        end else if (scan.scan_en) begin
            if (nonzero) begin
                run_list_o[new_idx] <= '0;
            end else if (open_run) begin
                run_list_o[cur_idx] <= run_list_o[cur_idx] + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cavlc_stats_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

module cavlc_stats_top (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       stream_reset_i,
    input  wire logic                       valid_i,
    input  wire logic                       enc_ready_i,
    input  wire logic [`CAVLC_POS_W-1:0]    pos_x_i,
    input  wire logic [`CAVLC_POS_W-1:0]    pos_y_i,
    input  cavlc_pkg::coeff_t               block_i [`CAVLC_BLOCK_SIZE],
    output logic                            ready_o,
    output logic                            valid_o,
    output logic [`CAVLC_POS_W-1:0]         pos_x_o,
    output logic [`CAVLC_POS_W-1:0]         pos_y_o,
    output cavlc_pkg::run_t                 total_coeff_o,
    output cavlc_pkg::run_t                 total_zeros_o,
    output logic [1:0]                      t1_count_o,
    output cavlc_pkg::t1_flags_t            t1_flags_o,
    output cavlc_pkg::level_t               level_list_o [`CAVLC_BLOCK_SIZE],
    output cavlc_pkg::run_t                 level_count_o,
    output cavlc_pkg::run_t                 run_list_o [`CAVLC_BLOCK_SIZE],
    output cavlc_pkg::run_t                 run_count_o
);

    logic load;
    logic t1_done;

    coeff_scan_if scan_bus ();

    cavlc_scan_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .stream_reset_i (stream_reset_i),
        .valid_i        (valid_i),
        .enc_ready_i    (enc_ready_i),
        .pos_x_i        (pos_x_i),
        .pos_y_i        (pos_y_i),
        .load_o         (load),
        .ready_o        (ready_o),
        .valid_o        (valid_o),
        .pos_x_o        (pos_x_o),
        .pos_y_o        (pos_y_o),
        .scan           (scan_bus.ctrl)
    );

    cavlc_block_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .load_i  (load),
        .block_i (block_i),
        .scan    (scan_bus.src)
    );

    coeff_count_unit u_count (
        .clk           (clk),
        .rst           (rst),
        .scan          (scan_bus.unit),
        .total_coeff_o (total_coeff_o),
        .total_zeros_o (total_zeros_o)
    );

    trailing_ones_unit u_t1 (
        .clk        (clk),
        .rst        (rst),
        .scan       (scan_bus.unit),
        .t1_count_o (t1_count_o),
        .t1_flags_o (t1_flags_o),
        .t1_done_o  (t1_done)
    );

    level_list_unit u_levels (
        .clk           (clk),
        .rst           (rst),
        .scan          (scan_bus.unit),
        .t1_done_i     (t1_done),
        .level_list_o  (level_list_o),
        .level_count_o (level_count_o)
    );

    run_before_unit u_runs (
        .clk         (clk),
        .rst         (rst),
        .scan        (scan_bus.unit),
        .run_list_o  (run_list_o),
        .run_count_o (run_count_o)
    );

endmodule

`default_nettype wire

//--- tb/cavlc_stats_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cavlc_stats_assert (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       stream_reset_i,
    input  wire logic       ready_o,
    input  wire logic       valid_o,
    input  wire logic       enc_ready_i,
    input  wire logic [1:0] t1_count_o,
    input  cavlc_pkg::run_t total_coeff_o,
    input  cavlc_pkg::run_t total_zeros_o,
    input  cavlc_pkg::run_t level_count_o
);

    int unsigned fail_count = 0;

    handshake_excl: assert property (@(posedge clk) disable iff (rst)
        !(ready_o && valid_o))
    else begin
        fail_count++;
        $error("ready_o and valid_o are high together");
    end

    // A result stays up until the encoder takes it.
    valid_hold: assert property (@(posedge clk) disable iff (rst)
        valid_o && !enc_ready_i && !stream_reset_i |=> valid_o)
    else begin
        fail_count++;
        $error("valid_o dropped before enc_ready_i");
    end

    count_bound: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> (int'(total_coeff_o) + int'(total_zeros_o) <= 16))
    else begin
        fail_count++;
        $error("total_coeff_o plus total_zeros_o exceeds the block size");
    end

    level_split: assert property (@(posedge clk) disable iff (rst)
        valid_o |-> (int'(level_count_o) + int'(t1_count_o) == int'(total_coeff_o)))
    else begin
        fail_count++;
        $error("level_count_o plus t1_count_o differs from total_coeff_o");
    end

endmodule

`default_nettype wire

//--- tb/cavlc_stats_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cavlc_macros.svh"

module cavlc_stats_tb;

    localparam int NUM_BLOCKS = 16;
    localparam int NUM_FIXED  = 8;
    localparam int BLK        = `CAVLC_BLOCK_SIZE;
    localparam int POS_W      = `CAVLC_POS_W;
    localparam int LATENCY    = 18;
    localparam int ZIGZAG [16] = '{0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15};

    // Fixed blocks in raster order.
    // All zero, four ones, large first level, all nonzero, then a few typical residuals.
    localparam int FIXED_TBL [8][16] = '{
        '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{0, 1, 0, 0, -1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, -1},
        '{5, -1, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, -3},
        '{7, -6, 5, -4, 3, -2, 1, -1, 2, 1, -1, 1, 4, -5, 1, -1},
        '{0, 3, -1, 0, 0, -1, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0},
        '{-1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{127, 0, 0, -128, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1},
        '{0, 0, 2, 0, 1, 0, 0, -1, 0, 1, 0, 0, 0, 0, -1, 0}
    };

    logic                       clk;
    logic                       rst;
    logic                       stream_reset_i;
    logic                       valid_i;
    logic                       enc_ready_i;
    logic [POS_W-1:0]           pos_x_i;
    logic [POS_W-1:0]           pos_y_i;
    cavlc_pkg::coeff_t          block_i [BLK];
    logic                       ready_o;
    logic                       valid_o;
    logic [POS_W-1:0]           pos_x_o;
    logic [POS_W-1:0]           pos_y_o;
    cavlc_pkg::run_t            total_coeff_o;
    cavlc_pkg::run_t            total_zeros_o;
    logic [1:0]                 t1_count_o;
    cavlc_pkg::t1_flags_t       t1_flags_o;
    cavlc_pkg::level_t          level_list_o [BLK];
    cavlc_pkg::run_t            level_count_o;
    cavlc_pkg::run_t            run_list_o [BLK];
    cavlc_pkg::run_t            run_count_o;

    // One row of stimulus and expected values per block.
    cavlc_pkg::coeff_t          tbl_blk [NUM_BLOCKS][BLK];
    logic [POS_W-1:0]           tbl_px [NUM_BLOCKS];
    logic [POS_W-1:0]           tbl_py [NUM_BLOCKS];
    int                         tbl_hold [NUM_BLOCKS];
    cavlc_pkg::run_t            exp_tc [NUM_BLOCKS];
    cavlc_pkg::run_t            exp_tz [NUM_BLOCKS];
    cavlc_pkg::run_t            exp_t1 [NUM_BLOCKS];
    cavlc_pkg::t1_flags_t       exp_flags [NUM_BLOCKS];
    cavlc_pkg::run_t            exp_nl [NUM_BLOCKS];
    cavlc_pkg::level_t          exp_levels [NUM_BLOCKS][BLK];
    cavlc_pkg::run_t            exp_runs [NUM_BLOCKS][BLK];
    int                         seed;

    cavlc_stats_top DUT (.*);

    bind cavlc_stats_top cavlc_stats_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (NUM_BLOCKS * 40 + 100) @(posedge clk);
        $display("Timeout: the DUT stopped producing results before all blocks were checked.");
        $display("Regression failed");
        $fatal(1, "Watchdog expired.");
    end

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("ERR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        $display("Regression failed");
        $fatal(1, "Stopped at the first mismatch.");
    endtask

    task automatic check_run(input string what, input cavlc_pkg::run_t got,
                             input cavlc_pkg::run_t exp);
        if (got !== exp) report_mismatch(what, int'(got), int'(exp));
    endtask

    task automatic check_level(input string what, input cavlc_pkg::level_t got,
                               input cavlc_pkg::level_t exp);
        if (got !== exp) report_mismatch(what, int'(got), int'(exp));
    endtask

    task automatic check_flags(input string what, input cavlc_pkg::t1_flags_t got,
                               input cavlc_pkg::t1_flags_t exp);
        if (got !== exp) report_mismatch(what, int'(got), int'(exp));
    endtask

    task automatic check_pos(input string what, input logic [POS_W-1:0] got,
                             input logic [POS_W-1:0] exp);
        if (got !== exp) report_mismatch(what, int'(got), int'(exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) report_mismatch(what, int'(got), int'(exp));
    endtask

    // Walks the block in reverse zig-zag order and applies the CAVLC rules.
    task automatic compute_expected(input int b);
        cavlc_pkg::coeff_t c;
        int tc;
        int tz;
        int t1;
        int nl;
        bit t1_end;
        tc = 0;
        tz = 0;
        t1 = 0;
        nl = 0;
        t1_end = 1'b0;
        exp_flags[b] = '0;
        for (int i = 0; i < BLK; i++) begin
            exp_levels[b][i] = '0;
            exp_runs[b][i] = '0;
        end
        for (int k = 0; k < BLK; k++) begin
            c = tbl_blk[b][ZIGZAG[BLK - 1 - k]];
            if (c == 0) begin
                if (tc > 0) begin
                    tz++;
                    exp_runs[b][tc - 1] = cavlc_pkg::run_t'(int'(exp_runs[b][tc - 1]) + 1);
                end
            end else begin
                if (!t1_end && t1 < 3 && (c == 1 || c == -1)) begin
                    exp_flags[b][t1] = (c < 0);
                    t1++;
                end else begin
                    t1_end = 1'b1;
                    exp_levels[b][nl] = cavlc_pkg::level_t'(c);
                    nl++;
                end
                tc++;
            end
        end
        exp_tc[b] = cavlc_pkg::run_t'(tc);
        exp_tz[b] = cavlc_pkg::run_t'(tz);
        exp_t1[b] = cavlc_pkg::run_t'(t1);
        exp_nl[b] = cavlc_pkg::run_t'(nl);
    endtask

    task automatic build_table();
        int r;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int i = 0; i < BLK; i++) begin
                r = $random(seed);
                if (b < NUM_FIXED) begin
                    tbl_blk[b][i] = cavlc_pkg::coeff_t'(FIXED_TBL[b][i]);
                end else if (r[3:0] == 4'd0) begin
                    tbl_blk[b][i] = cavlc_pkg::coeff_t'(r[15:8]);
                end else begin
                    tbl_blk[b][i] = cavlc_pkg::coeff_t'(int'(r[10:8]) % 5 - 2);
                end
            end
            tbl_px[b] = POS_W'(b * 37 + 3);
            tbl_py[b] = POS_W'($random(seed));
            tbl_hold[b] = $unsigned($random(seed)) % 11;
            compute_expected(b);
        end
    endtask

    task automatic check_idle();
        check_bit("ready_o", ready_o, 1'b1);
        check_bit("valid_o", valid_o, 1'b0);
        check_run("total_coeff_o", total_coeff_o, '0);
        check_run("total_zeros_o", total_zeros_o, '0);
        check_run("t1_count_o", cavlc_pkg::run_t'(t1_count_o), '0);
        check_flags("t1_flags_o", t1_flags_o, '0);
        check_run("level_count_o", level_count_o, '0);
        check_run("run_count_o", run_count_o, '0);
        for (int i = 0; i < BLK; i++) begin
            check_level($sformatf("level_list_o[%0d]", i), level_list_o[i], '0);
            check_run($sformatf("run_list_o[%0d]", i), run_list_o[i], '0);
        end
    endtask

    task automatic check_result(input int b);
        check_run("total_coeff_o", total_coeff_o, exp_tc[b]);
        check_run("total_zeros_o", total_zeros_o, exp_tz[b]);
        check_run("t1_count_o", cavlc_pkg::run_t'(t1_count_o), exp_t1[b]);
        check_flags("t1_flags_o", t1_flags_o, exp_flags[b]);
        check_run("level_count_o", level_count_o, exp_nl[b]);
        check_run("run_count_o", run_count_o, exp_tc[b]);
        check_pos("pos_x_o", pos_x_o, tbl_px[b]);
        check_pos("pos_y_o", pos_y_o, tbl_py[b]);
        for (int i = 0; i < BLK; i++) begin
            check_level($sformatf("level_list_o[%0d]", i), level_list_o[i], exp_levels[b][i]);
            check_run($sformatf("run_list_o[%0d]", i), run_list_o[i], exp_runs[b][i]);
        end
    endtask

    task present_block(input int b);
        block_i <= tbl_blk[b];
        pos_x_i <= tbl_px[b];
        pos_y_i <= tbl_py[b];
        valid_i <= 1'b1;
    endtask

    // Entered and left just after a falling edge, with block b on the inputs.
    task run_block(input int b);
        int cycles;
        while (!ready_o) @(negedge clk);
        @(posedge clk);
        valid_i <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!valid_o) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end
        if (cycles != LATENCY) report_mismatch("valid_o latency", cycles, LATENCY);
        check_result(b);
        for (int h = 0; h < tbl_hold[b]; h++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("valid_o", valid_o, 1'b1);
            check_bit("ready_o", ready_o, 1'b0);
            check_result(b);
        end
        // Next block goes up with the release so valid_i spans it.
        @(posedge clk);
        enc_ready_i <= 1'b1;
        if (b + 1 < NUM_BLOCKS) present_block(b + 1);
        @(negedge clk);
        check_bit("valid_o", valid_o, 1'b1);
        @(posedge clk);
        enc_ready_i <= 1'b0;
        @(negedge clk);
        check_idle();
    endtask

    initial begin
        rst = 1'b1;
        stream_reset_i = 1'b0;
        valid_i = 1'b0;
        enc_ready_i = 1'b0;
        pos_x_i = '0;
        pos_y_i = '0;
        for (int i = 0; i < BLK; i++) begin
            block_i[i] = '0;
        end
        seed = 29282;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle();
        check_pos("pos_x_o", pos_x_o, '0);

        // Abort the all-nonzero block halfway through its scan.
        @(posedge clk);
        present_block(3);
        @(negedge clk);
        @(posedge clk);
        valid_i <= 1'b0;
        repeat (8) @(posedge clk);
        stream_reset_i <= 1'b1;
        @(posedge clk);
        stream_reset_i <= 1'b0;
        @(negedge clk);
        check_idle();
        check_pos("pos_y_o", pos_y_o, '0);

        @(posedge clk);
        present_block(0);
        @(negedge clk);
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            run_block(b);
        end

        if (DUT.u_assert.fail_count != 0) begin
            $display("Bound assertions on the DUT reported %0d failures.",
                     DUT.u_assert.fail_count);
            $display("Regression failed");
            $fatal(1, "Assertion failures.");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- cavlc_stats_top.f
+incdir+hw
hw/cavlc_pkg.sv
hw/coeff_scan_if.sv
hw/cavlc_block_buffer.sv
hw/cavlc_scan_ctrl.sv
hw/coeff_count_unit.sv
hw/trailing_ones_unit.sv
hw/level_list_unit.sv
hw/run_before_unit.sv
hw/cavlc_stats_top.sv
tb/cavlc_stats_assert.sv
tb/cavlc_stats_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run; the result is taken from the simulation output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cavlc_stats_tb \
    -f cavlc_stats_top.f -o cavlc_stats_sim &&
./obj_dir/cavlc_stats_sim 2>&1 | tee /dev/stderr | grep -q "Regression passed" ||
{ echo "Simulation did not pass."; exit 1; }
